// ==== Makefile ====
# Verilator build and run for the multi-queue packet buffer

VERILATOR ?= verilator
TOP       ?= sram_fifo_tb
RTL_TOP   ?= sram_fifo_top
FILELIST  ?= sram_fifo_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_TEXT := SOME TESTS FAILED

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_TEXT)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/buf_if.sv ====
`timescale 1ns/1ns

interface buf_if
    import sram_fifo_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int NUM_QUEUES = DEFAULT_NUM_QUEUES
);

    localparam int QW = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;

    // write side, words carry last in the top bit
    logic                  wr_en;
    logic [QW-1:0]         wr_queue;
    logic [DATA_WIDTH:0]   wr_word;
    logic [NUM_QUEUES-1:0] wr_full;

    // read side
    logic                  rd_en;
    logic [QW-1:0]         rd_queue;
    logic [NUM_QUEUES-1:0] rd_empty;
    logic                  rd_valid;
    logic [DATA_WIDTH:0]   rd_word;
    logic [QW-1:0]         rd_word_queue;

    modport ingress (output wr_en, wr_queue, wr_word, input wr_full);
    modport egress (output rd_en, rd_queue, input rd_empty, rd_valid, rd_word, rd_word_queue);
    modport buffer (input wr_en, wr_queue, wr_word, rd_en, rd_queue,
                    output wr_full, rd_empty, rd_valid, rd_word, rd_word_queue);

endinterface

// ==== rtl/egress_arbiter.sv ====
`timescale 1ns/1ns

module egress_arbiter
    import sram_fifo_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int NUM_QUEUES = DEFAULT_NUM_QUEUES,
    parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
)
(
    input  logic                            clk,
    input  logic                            memreset,
    buf_if.egress                           buf_port,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count [NUM_QUEUES],
    output logic [NUM_QUEUES-1:0]           fifo_push,
    output logic [DATA_WIDTH:0]             push_data
);

    localparam int QW = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
    localparam int PW = $clog2(MAX_QUEUES);
    localparam int BW = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    burst_state_t          state;
    logic [QW-1:0]         grant;
    logic [BW-1:0]         beats;
    logic [CW-1:0]         inflight [NUM_QUEUES];
    logic [NUM_QUEUES-1:0] req;
    logic [NUM_QUEUES-1:0] rd_sel;
    logic [PW-1:0]         pick;
    logic                  move;

    // a read needs a word in the region and a free slot downstream
    always_comb
    begin
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            req[q]       = !buf_port.rd_empty[q]
                         && (int'(fifo_count[q]) + int'(inflight[q]) < FIFO_DEPTH);
            rd_sel[q]    = move && (grant == QW'(q));
            fifo_push[q] = buf_port.rd_valid && (buf_port.rd_word_queue == QW'(q));
        end
        pick = rr_pick(MAX_QUEUES'(req), PW'(grant), NUM_QUEUES);
    end

    assign move             = (state == BURST_ACTIVE) && req[grant];
    assign buf_port.rd_en   = move;
    assign buf_port.rd_queue = grant;
    assign push_data        = buf_port.rd_word;

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            state <= BURST_IDLE;
            grant <= QW'(NUM_QUEUES - 1);
            beats <= '0;
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                inflight[q] <= '0;
            end
        end
        else
        begin
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                inflight[q] <= inflight[q] + CW'(rd_sel[q]) - CW'(fifo_push[q]);
            end
            if (state == BURST_IDLE && |req)
            begin
                state <= BURST_ACTIVE;
                grant <= pick[QW-1:0];
                beats <= '0;
            end
            else if (state == BURST_ACTIVE)
            begin
                if (!move || beats == BW'(BURST_LEN - 1))
                begin
                    state <= BURST_IDLE;
                end
                beats <= beats + BW'(move);
            end
        end
    end

    // credits keep every returned word in bounds
    for (genvar q = 0; q < NUM_QUEUES; q++)
    begin : g_credit_check
        assert property (@(posedge clk) disable iff (memreset)
            fifo_push[q] |-> int'(fifo_count[q]) < FIFO_DEPTH);
    end

endmodule

// ==== rtl/ingress_arbiter.sv ====
`timescale 1ns/1ns

module ingress_arbiter
    import sram_fifo_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int NUM_QUEUES = DEFAULT_NUM_QUEUES
)
(
    input  logic                  clk,
    input  logic                  memreset,
    input  logic [NUM_QUEUES-1:0] fifo_empty,
    output logic [NUM_QUEUES-1:0] fifo_pop,
    input  logic [DATA_WIDTH:0]   fifo_data [NUM_QUEUES],
    buf_if.ingress                buf_port
);

    localparam int QW = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
    localparam int PW = $clog2(MAX_QUEUES);
    localparam int BW = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

    burst_state_t          state;
    logic [QW-1:0]         grant;
    logic [BW-1:0]         beats;
    logic [NUM_QUEUES-1:0] req;
    logic [PW-1:0]         pick;
    logic                  move;
    logic                  burst_done;

    // words waiting and room in the region
    assign req = ~fifo_empty & ~buf_port.wr_full;

    always_comb
    begin
        pick = rr_pick(MAX_QUEUES'(req), PW'(grant), NUM_QUEUES);
    end

    assign move       = (state == BURST_ACTIVE) && req[grant];
    assign burst_done = (beats == BW'(BURST_LEN - 1)) || fifo_data[grant][DATA_WIDTH];

    always_comb
    begin
        fifo_pop        = '0;
        fifo_pop[grant] = move;
    end

    assign buf_port.wr_en    = move;
    assign buf_port.wr_queue = grant;
    assign buf_port.wr_word  = fifo_data[grant];

    //////////////////////////////
    // grant state machine
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            state <= BURST_IDLE;
            // start the rotation at queue 0
            grant <= QW'(NUM_QUEUES - 1);
            beats <= '0;
        end
        else
        begin
            case (state)
                BURST_IDLE:
                begin
                    if (|req)
                    begin
                        state <= BURST_ACTIVE;
                        grant <= pick[QW-1:0];
                        beats <= '0;
                    end
                end
                BURST_ACTIVE:
                begin
                    if (!move || burst_done)
                    begin
                        state <= BURST_IDLE;
                    end
                    beats <= beats + BW'(move);
                end
                default:
                begin
                    state <= BURST_IDLE;
                end
            endcase
        end
    end

    // a head word waiting for its grant stays put
    for (genvar q = 0; q < NUM_QUEUES; q++)
    begin : g_head_check
        assert property (@(posedge clk) disable iff (memreset)
            (!fifo_empty[q] && !fifo_pop[q]) |=> $stable(fifo_data[q]));
    end

endmodule

// ==== rtl/queue_buffer.sv ====
`timescale 1ns/1ns

module queue_buffer
    import sram_fifo_pkg::*;
#(
    parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH,
    parameter int NUM_QUEUES   = DEFAULT_NUM_QUEUES,
    parameter int REGION_DEPTH = DEFAULT_REGION_DEPTH
)
(
    input logic   clk,
    input logic   memreset,
    buf_if.buffer buf_port
);

    localparam int QW    = (NUM_QUEUES > 1) ? $clog2(NUM_QUEUES) : 1;
    localparam int RW    = (REGION_DEPTH > 1) ? $clog2(REGION_DEPTH) : 1;
    localparam int CW    = $clog2(REGION_DEPTH + 1);
    localparam int WORDS = NUM_QUEUES * REGION_DEPTH;
    localparam int AW    = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [DATA_WIDTH:0]   mem [WORDS];
    logic [RW-1:0]         head [NUM_QUEUES];
    logic [RW-1:0]         tail [NUM_QUEUES];
    logic [CW-1:0]         count [NUM_QUEUES];
    logic [NUM_QUEUES-1:0] wr_sel;
    logic [NUM_QUEUES-1:0] rd_sel;
    logic [AW-1:0]         wr_addr;
    logic [AW-1:0]         rd_addr;

    //////////////////////////////
    // per-queue status
    //////////////////////////////
    always_comb
    begin
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            wr_sel[q]            = buf_port.wr_en && (buf_port.wr_queue == QW'(q));
            rd_sel[q]            = buf_port.rd_en && (buf_port.rd_queue == QW'(q));
            buf_port.wr_full[q]  = (count[q] == CW'(REGION_DEPTH));
            buf_port.rd_empty[q] = (count[q] == '0);
        end
    end

    // region base plus offset inside the region
    assign wr_addr = AW'(buf_port.wr_queue) * AW'(REGION_DEPTH)
                   + AW'(tail[buf_port.wr_queue]);
    assign rd_addr = AW'(buf_port.rd_queue) * AW'(REGION_DEPTH)
                   + AW'(head[buf_port.rd_queue]);

    //////////////////////////////
    // storage and read port
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (buf_port.wr_en)
        begin
            mem[wr_addr] <= buf_port.wr_word;
        end
        if (buf_port.rd_en)
        begin
            buf_port.rd_word       <= mem[rd_addr];
            buf_port.rd_word_queue <= buf_port.rd_queue;
        end
    end

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            buf_port.rd_valid <= 1'b0;
        end
        else
        begin
            buf_port.rd_valid <= buf_port.rd_en;
        end
    end

    // circular pointers, one pair per region
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                head[q]  <= '0;
                tail[q]  <= '0;
                count[q] <= '0;
            end
        end
        else
        begin
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                if (wr_sel[q])
                begin
                    tail[q] <= (tail[q] == RW'(REGION_DEPTH - 1)) ? '0 : tail[q] + 1'b1;
                end
                if (rd_sel[q])
                begin
                    head[q] <= (head[q] == RW'(REGION_DEPTH - 1)) ? '0 : head[q] + 1'b1;
                end
                count[q] <= count[q] + CW'(wr_sel[q]) - CW'(rd_sel[q]);
            end
        end
    end

    assert property (@(posedge clk) disable iff (memreset)
        buf_port.wr_en |-> !buf_port.wr_full[buf_port.wr_queue]);
    assert property (@(posedge clk) disable iff (memreset)
        buf_port.rd_en |-> !buf_port.rd_empty[buf_port.rd_queue]);

endmodule

// ==== rtl/queue_fifo.sv ====
`timescale 1ns/1ns

module queue_fifo
    import sram_fifo_pkg::*;
#(
    parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH,
    parameter int DEPTH      = DEFAULT_FIFO_DEPTH
)
(
    input  logic                       clk,
    input  logic                       memreset,
    input  logic                       push,
    input  logic [DATA_WIDTH:0]        push_data,
    output logic                       full,
    input  logic                       pop,
    output logic [DATA_WIDTH:0]        pop_data,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [DATA_WIDTH:0] mem [DEPTH];
    logic [AW-1:0]       wr_ptr;
    logic [AW-1:0]       rd_ptr;
    logic [CW-1:0]       count_next;

    assign count_next = count + CW'(push) - CW'(pop);

    // head word is always on the output
    assign pop_data = mem[rd_ptr];
    assign empty    = (count == '0);

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            // held full so nothing is accepted in reset
            full   <= 1'b1;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == CW'(DEPTH));
        end
    end

    // neighbours must respect the flags
    assert property (@(posedge clk) disable iff (memreset)
        !(push && full) && !(pop && empty));

endmodule

// ==== rtl/sram_fifo_pkg.sv ====
package sram_fifo_pkg;

    //////////////////////////////
    // defaults and limits
    //////////////////////////////
    localparam int DEFAULT_DATA_WIDTH   = 64;
    localparam int DEFAULT_NUM_QUEUES   = 4;
    localparam int DEFAULT_REGION_DEPTH = 32;
    localparam int DEFAULT_FIFO_DEPTH   = 8;
    localparam int MAX_QUEUES           = 16;

    // longest run of words per grant
    localparam int BURST_LEN = 4;

    typedef enum logic [1:0]
    {
        BURST_IDLE   = 2'd0,
        BURST_ACTIVE = 2'd1
    } burst_state_t;

    // first requester after the last grant, wrapping at num_queues
    function automatic logic [$clog2(MAX_QUEUES)-1:0] rr_pick
    (
        input logic [MAX_QUEUES-1:0]         req,
        input logic [$clog2(MAX_QUEUES)-1:0] last,
        input int                            num_queues
    );
        logic [$clog2(MAX_QUEUES)-1:0] pick;
        int                            idx;
        pick = last;
        // walk backwards so the nearest requester is written last
        for (int k = MAX_QUEUES; k >= 1; k--)
        begin
            idx = (int'(last) + k) % num_queues;
            if (k <= num_queues && req[idx])
            begin
                pick = idx[$clog2(MAX_QUEUES)-1:0];
            end
        end
        return pick;
    endfunction

endpackage

// ==== rtl/sram_fifo_top.sv ====
`timescale 1ns/1ns

module sram_fifo_top
    import sram_fifo_pkg::*;
#(
    parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH,
    parameter int NUM_QUEUES   = DEFAULT_NUM_QUEUES,
    parameter int REGION_DEPTH = DEFAULT_REGION_DEPTH,
    parameter int FIFO_DEPTH   = DEFAULT_FIFO_DEPTH
)
(
    input  logic                  clk,
    input  logic                  memreset,
    input  logic [DATA_WIDTH-1:0] s_tdata [NUM_QUEUES],
    input  logic [NUM_QUEUES-1:0] s_tlast,
    input  logic [NUM_QUEUES-1:0] s_tvalid,
    output logic [NUM_QUEUES-1:0] s_tready,
    output logic [DATA_WIDTH-1:0] m_tdata [NUM_QUEUES],
    output logic [NUM_QUEUES-1:0] m_tlast,
    output logic [NUM_QUEUES-1:0] m_tvalid,
    input  logic [NUM_QUEUES-1:0] m_tready
);

    logic [NUM_QUEUES-1:0]           in_full;
    logic [NUM_QUEUES-1:0]           in_empty;
    logic [NUM_QUEUES-1:0]           in_pop;
    logic [DATA_WIDTH:0]             in_word [NUM_QUEUES];
    logic [NUM_QUEUES-1:0]           eg_push;
    logic [NUM_QUEUES-1:0]           eg_empty;
    logic [DATA_WIDTH:0]             eg_push_data;
    logic [DATA_WIDTH:0]             eg_word [NUM_QUEUES];
    logic [$clog2(FIFO_DEPTH+1)-1:0] eg_count [NUM_QUEUES];

    buf_if #(.DATA_WIDTH(DATA_WIDTH), .NUM_QUEUES(NUM_QUEUES)) mem_bus ();

    //////////////////////////////
    // ingress side
    //////////////////////////////
    for (genvar q = 0; q < NUM_QUEUES; q++)
    begin : g_ingress
        queue_fifo #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_fifo (
            .clk       (clk),
            .memreset  (memreset),
            .push      (s_tvalid[q] & s_tready[q]),
            .push_data ({s_tlast[q], s_tdata[q]}),
            .full      (in_full[q]),
            .pop       (in_pop[q]),
            .pop_data  (in_word[q]),
            .empty     (in_empty[q]),
            .count     ()
        );
        assign s_tready[q] = ~in_full[q];
    end

    ingress_arbiter #(.DATA_WIDTH(DATA_WIDTH), .NUM_QUEUES(NUM_QUEUES)) u_ingress_arbiter (
        .clk        (clk),
        .memreset   (memreset),
        .fifo_empty (in_empty),
        .fifo_pop   (in_pop),
        .fifo_data  (in_word),
        .buf_port   (mem_bus.ingress)
    );

    queue_buffer #(
        .DATA_WIDTH   (DATA_WIDTH),
        .NUM_QUEUES   (NUM_QUEUES),
        .REGION_DEPTH (REGION_DEPTH)
    ) u_queue_buffer (
        .clk      (clk),
        .memreset (memreset),
        .buf_port (mem_bus.buffer)
    );

    egress_arbiter #(
        .DATA_WIDTH (DATA_WIDTH),
        .NUM_QUEUES (NUM_QUEUES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_egress_arbiter (
        .clk        (clk),
        .memreset   (memreset),
        .buf_port   (mem_bus.egress),
        .fifo_count (eg_count),
        .fifo_push  (eg_push),
        .push_data  (eg_push_data)
    );

    //////////////////////////////
    // egress side
    //////////////////////////////
    for (genvar q = 0; q < NUM_QUEUES; q++)
    begin : g_egress
        queue_fifo #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(FIFO_DEPTH)) u_fifo (
            .clk       (clk),
            .memreset  (memreset),
            .push      (eg_push[q]),
            .push_data (eg_push_data),
            .full      (),
            .pop       (m_tready[q] & ~eg_empty[q]),
            .pop_data  (eg_word[q]),
            .empty     (eg_empty[q]),
            .count     (eg_count[q])
        );
        assign m_tvalid[q] = ~eg_empty[q];
        assign m_tdata[q]  = eg_word[q][DATA_WIDTH-1:0];
        assign m_tlast[q]  = eg_word[q][DATA_WIDTH];
    end

endmodule

// ==== sram_fifo_top.f ====
rtl/sram_fifo_pkg.sv
rtl/buf_if.sv
rtl/queue_fifo.sv
rtl/ingress_arbiter.sv
rtl/queue_buffer.sv
rtl/egress_arbiter.sv
rtl/sram_fifo_top.sv
tests/sram_fifo_tb.sv

// ==== tests/sram_fifo_tb.sv ====
`timescale 1ns/1ns

module sram_fifo_tb
    import sram_fifo_pkg::*;
;

    localparam int DW               = DEFAULT_DATA_WIDTH;
    localparam int NQ               = DEFAULT_NUM_QUEUES;
    localparam int CAPACITY         = 2 * DEFAULT_FIFO_DEPTH + DEFAULT_REGION_DEPTH;
    localparam int RESET_CYCLES     = 16;
    localparam int SINGLE_MAX       = 36;
    localparam int CONC_WORDS       = 40;
    localparam int RAND_WORDS       = 60;
    localparam int STALL_FLOW_WORDS = 200;
    localparam int STALL_WORDS      = 80;
    localparam int STALL_HOLD       = 64;
    // about eight cycles per word covers arbitration and random gaps
    localparam int TIMEOUT_CYCLES   = RESET_CYCLES + 1000 + 8 * (SINGLE_MAX + NQ * CONC_WORDS
                                    + NQ * RAND_WORDS + STALL_FLOW_WORDS + STALL_WORDS);

    logic          clk;
    logic          memreset;
    logic [DW-1:0] s_tdata [NQ];
    logic [NQ-1:0] s_tlast;
    logic [NQ-1:0] s_tvalid;
    logic [NQ-1:0] s_tready;
    logic [DW-1:0] m_tdata [NQ];
    logic [NQ-1:0] m_tlast;
    logic [NQ-1:0] m_tvalid;
    logic [NQ-1:0] m_tready;

    logic [31:0]   lfsr;
    logic [DW:0]   sb [NQ][$];
    logic [DW:0]   head_word [NQ];
    logic [NQ-1:0] sb_empty;
    logic [NQ-1:0] pend;
    logic [NQ-1:0] ready_mask;
    bit            rand_valid;
    bit            rand_ready;
    int            out_count [NQ];
    int            accepted [NQ];
    int            send_left [NQ];
    int            pkt_left [NQ];
    int            seq [NQ];
    int            errors;
    int            tests_passed;
    int            tests_failed;
    int            test_errors_start;
    int            cycles;
    string         test_name;

    sram_fifo_top UUT (
        .clk      (clk),
        .memreset (memreset),
        .s_tdata  (s_tdata),
        .s_tlast  (s_tlast),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .m_tdata  (m_tdata),
        .m_tlast  (m_tlast),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // random source
    //////////////////////////////
    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic coin_flip();
        logic [31:0] v;
        v = random_bits(1);
        return v[0];
    endfunction

    //////////////////////////////
    // scoreboards
    //////////////////////////////
    always @(posedge clk)
    begin
        for (int q = 0; q < NQ; q++)
        begin
            if (!memreset && m_tvalid[q] && m_tready[q])
            begin
                out_count[q]++;
                if (sb[q].size() > 0)
                begin
                    void'(sb[q].pop_front());
                end
            end
            if (!memreset && s_tvalid[q] && s_tready[q])
            begin
                sb[q].push_back({s_tlast[q], s_tdata[q]});
            end
            sb_empty[q]  <= (sb[q].size() == 0);
            head_word[q] <= (sb[q].size() == 0) ? '0 : sb[q][0];
        end
    end

    // data carries the queue number, so a word on the wrong queue mismatches
    for (genvar q = 0; q < NQ; q++)
    begin : g_output_check
        assert property (@(posedge clk) disable iff (memreset)
            (m_tvalid[q] && m_tready[q]) |-> !sb_empty[q])
        else
        begin
            $display("%s: queue %0d delivered a word that was never accepted", test_name, q);
            errors++;
        end
        assert property (@(posedge clk) disable iff (memreset)
            (m_tvalid[q] && m_tready[q] && !sb_empty[q])
            |-> ({m_tlast[q], m_tdata[q]} == head_word[q]))
        else
        begin
            $display("[FAIL] %s: queue %0d expected %h actual %h",
                     test_name, q, head_word[q], {m_tlast[q], m_tdata[q]});
            errors++;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    task automatic drive_cycle();
        @(posedge clk);
        for (int q = 0; q < NQ; q++)
        begin
            if (pend[q] && s_tready[q])
            begin
                pend[q] = 1'b0;
                accepted[q]++;
            end
            if (!pend[q] && send_left[q] > 0 && (!rand_valid || coin_flip()))
            begin
                if (pkt_left[q] == 0)
                begin
                    pkt_left[q] = 1 + int'(random_bits(3));
                end
                s_tdata[q]   <= {8'(q), 24'(seq[q]), random_bits(32)};
                s_tlast[q]   <= (pkt_left[q] == 1) || (send_left[q] == 1);
                pkt_left[q]  = (send_left[q] == 1) ? 0 : pkt_left[q] - 1;
                seq[q]       = seq[q] + 1;
                send_left[q] = send_left[q] - 1;
                pend[q]      = 1'b1;
            end
            s_tvalid[q] <= pend[q];
            m_tready[q] <= ready_mask[q] && (!rand_ready || coin_flip());
        end
    endtask

    function automatic bit words_left();
        bit any;
        any = 1'b0;
        for (int q = 0; q < NQ; q++)
        begin
            any |= (send_left[q] > 0);
        end
        return any;
    endfunction

    function automatic bit outputs_drained();
        bit done;
        done = (m_tvalid == '0);
        for (int q = 0; q < NQ; q++)
        begin
            done &= (sb[q].size() == 0);
        end
        return done;
    endfunction

    task automatic send_all();
        while (pend != '0 || words_left())
        begin
            drive_cycle();
        end
    endtask

    task automatic drain_all();
        while (!outputs_drained())
        begin
            drive_cycle();
        end
    endtask

    // every accepted word came out once
    task automatic check_counts();
        for (int q = 0; q < NQ; q++)
        begin
            assert (out_count[q] == accepted[q])
            else
            begin
                $display("[FAIL] %s: queue %0d word count expected %0d actual %0d",
                         test_name, q, accepted[q], out_count[q]);
                errors++;
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name         = name;
        test_errors_start = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors_start)
        begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - test_errors_start);
        end
    endtask

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        int low_run;
        int acc_start;
        int flow_start;
        lfsr         = 32'h3fcb;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        memreset     = 1'b1;
        s_tvalid     = '0;
        s_tlast      = '0;
        m_tready     = '0;
        pend         = '0;
        ready_mask   = '1;
        rand_valid   = 1'b0;
        rand_ready   = 1'b0;
        for (int q = 0; q < NQ; q++)
        begin
            s_tdata[q]   = '0;
            send_left[q] = 0;
            pkt_left[q]  = 0;
            seq[q]       = 0;
            accepted[q]  = 0;
            out_count[q] = 0;
        end

        begin_test("reset_state");
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1)
            begin
                memreset <= 1'b0;
            end
            else
            begin
                @(negedge clk);
                assert (s_tready == '0 && m_tvalid == '0)
                else
                begin
                    $display("s_tready or m_tvalid was high during reset");
                    errors++;
                end
            end
        end
        @(posedge clk);
        @(negedge clk);
        assert (s_tready == '1 && m_tvalid == '0)
        else
        begin
            $display("s_tready not up or m_tvalid not low on the first cycle after reset");
            errors++;
        end
        end_test();

        // one packet, all words on queue 0
        begin_test("single_queue_order");
        send_left[0] = 4 + int'(random_bits(5));
        pkt_left[0]  = send_left[0];
        send_all();
        drain_all();
        check_counts();
        end_test();

        begin_test("all_queues_concurrent");
        for (int q = 0; q < NQ; q++)
        begin
            send_left[q] = CONC_WORDS;
        end
        send_all();
        drain_all();
        check_counts();
        end_test();

        begin_test("random_backpressure");
        rand_valid = 1'b1;
        rand_ready = 1'b1;
        for (int q = 0; q < NQ; q++)
        begin
            send_left[q] = RAND_WORDS;
        end
        send_all();
        drain_all();
        check_counts();
        rand_valid = 1'b0;
        rand_ready = 1'b0;
        end_test();

        // queue 1 blocked at the output while queue 0 keeps moving
        begin_test("stall_capacity");
        ready_mask[1] = 1'b0;
        send_left[0]  = STALL_FLOW_WORDS;
        send_left[1]  = STALL_WORDS;
        acc_start     = accepted[1];
        flow_start    = out_count[0];
        low_run       = 0;
        while (low_run < STALL_HOLD)
        begin
            drive_cycle();
            low_run = s_tready[1] ? 0 : low_run + 1;
        end
        assert (accepted[1] - acc_start == CAPACITY)
        else
        begin
            $display("[FAIL] %s: stored words expected %0d actual %0d",
                     test_name, CAPACITY, accepted[1] - acc_start);
            errors++;
        end
        assert (out_count[0] > flow_start)
        else
        begin
            $display("%s: queue 0 stopped flowing while queue 1 was stalled", test_name);
            errors++;
        end
        send_left[0] = 0;
        send_left[1] = 0;
        ready_mask   = '1;
        send_all();
        drain_all();
        check_counts();
        end_test();

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
